// ==== filelist.f ====
+incdir+hdl
hdl/opm_pkg.sv
hdl/opm_timinggen.sv
hdl/opm_bus_reg.sv
hdl/opm_timer.sv
hdl/opm_top.sv
tests/opm_sva.sv
tests/opm_tb.sv

// ==== hdl/opm_bus_reg.sv ====
`timescale 1ns/1ns
`include "opm_params.svh"

module opm_bus_reg (
    input  logic                i_emuclk,
    input  logic                i_rst_n,
    input  logic                i_phi1_cen,
    input  logic                i_cs_n,
    input  logic                i_rd_n,
    input  logic                i_wr_n,
    input  logic                i_a0,
    input  opm_pkg::bus_data_t  i_d,
    input  logic                i_flag_a,
    input  logic                i_flag_b,
    output opm_pkg::bus_data_t  o_d,
    output logic                o_d_oe,
    output logic                o_ct1,
    output logic                o_ct2,
    output logic                o_irq_n,
    output logic                o_run_a,
    output logic                o_run_b,
    output logic                o_irqen_a,
    output logic                o_irqen_b,
    output logic                o_frst_a,
    output logic                o_frst_b,
    output opm_pkg::clka_t      o_clka,
    output opm_pkg::clkb_t      o_clkb
);
    import opm_pkg::*;

    localparam int BUSY_W = $clog2(`OPM_BUSY_CYCLES + 1);

    logic              wr_act;
    logic              wr_prev;
    logic              wr_pulse;
    logic              data_wr;
    logic              rd_act;
    logic              busy;
    logic [BUSY_W-1:0] busy_cnt;
    reg_addr_t         addr;
    bus_data_t         status;

    ////////////////////////////////////////////////////////////////////////////
    // write detection

    assign wr_act   = ~i_cs_n & ~i_wr_n;
    assign wr_pulse = wr_act & ~wr_prev;        // first clock of the strobe
    assign data_wr  = wr_pulse & i_a0;

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            wr_prev <= 1'b0;
            addr    <= '0;
        end else begin
            wr_prev <= wr_act;
            if (wr_pulse && !i_a0) begin
                addr <= i_d;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // control registers

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_clka    <= '0;
            o_clkb    <= '0;
            o_run_a   <= 1'b0;
            o_run_b   <= 1'b0;
            o_irqen_a <= 1'b0;
            o_irqen_b <= 1'b0;
            o_ct1     <= 1'b0;
            o_ct2     <= 1'b0;
        end else if (data_wr) begin
            case (addr)
                `OPM_ADDR_CLKA1: o_clka[9:2] <= i_d;
                `OPM_ADDR_CLKA2: o_clka[1:0] <= i_d[1:0];
                `OPM_ADDR_CLKB:  o_clkb      <= i_d;
                `OPM_ADDR_TIMERCTRL: begin
                    o_run_a   <= i_d[`OPM_BIT_RUN_A];
                    o_run_b   <= i_d[`OPM_BIT_RUN_B];
                    o_irqen_a <= i_d[`OPM_BIT_IRQEN_A];
                    o_irqen_b <= i_d[`OPM_BIT_IRQEN_B];
                end
                `OPM_ADDR_CT: begin
                    o_ct1 <= i_d[`OPM_BIT_CT1];
                    o_ct2 <= i_d[`OPM_BIT_CT2];
                end
                default: ;                      // dropped sound registers
            endcase
        end
    end

    // flag resets are strobes, not stored bits
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_frst_a <= 1'b0;
            o_frst_b <= 1'b0;
        end else begin
            o_frst_a <= data_wr && (addr == `OPM_ADDR_TIMERCTRL) && i_d[`OPM_BIT_FRST_A];
            o_frst_b <= data_wr && (addr == `OPM_ADDR_TIMERCTRL) && i_d[`OPM_BIT_FRST_B];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // busy, status read and interrupt

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(`OPM_BUSY_CYCLES);  // restarts on every data write
        end else if (i_phi1_cen && busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    always_comb begin
        status                   = '0;
        status[`OPM_STAT_BUSY]   = busy;
        status[`OPM_STAT_FLAG_B] = i_flag_b;
        status[`OPM_STAT_FLAG_A] = i_flag_a;
    end

    assign rd_act = ~i_cs_n & ~i_rd_n;

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_d_oe <= 1'b0;
            o_d    <= '0;
        end else begin
            o_d_oe <= rd_act;
            o_d    <= rd_act ? status : '0;
        end
    end

    assign o_irq_n = ~(i_flag_a | i_flag_b);   // flags only set with irq enabled

endmodule

// ==== hdl/opm_params.svh ====
`ifndef OPM_PARAMS_SVH
`define OPM_PARAMS_SVH

// register addresses
`define OPM_ADDR_CLKA1      8'h10   // timer A bits 9:2
`define OPM_ADDR_CLKA2      8'h11   // timer A bits 1:0
`define OPM_ADDR_CLKB       8'h12
`define OPM_ADDR_TIMERCTRL  8'h14
`define OPM_ADDR_CT         8'h1B

// timer control bits
`define OPM_BIT_RUN_A       0
`define OPM_BIT_RUN_B       1
`define OPM_BIT_IRQEN_A     2
`define OPM_BIT_IRQEN_B     3
`define OPM_BIT_FRST_A      4
`define OPM_BIT_FRST_B      5

// CT pins in register 0x1B
`define OPM_BIT_CT1         6
`define OPM_BIT_CT2         7

// status byte
`define OPM_STAT_BUSY       7
`define OPM_STAT_FLAG_B     1
`define OPM_STAT_FLAG_A     0

`define OPM_SLOTS           32
`define OPM_BUSY_CYCLES     32      // counted in phi1 enables
`define OPM_TIMERB_PRESCALE 16

`endif

// ==== hdl/opm_pkg.sv ====
`include "opm_params.svh"

package opm_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus and register widths

    // one byte on the chip data bus
    typedef logic [7:0] bus_data_t;

    // address latched by an A0 = 0 write
    typedef logic [7:0] reg_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // timer presets

    // timer A, CLKA1 on top of the two CLKA2 bits
    typedef logic [9:0] clka_t;

    // timer B
    typedef logic [7:0] clkb_t;

    ////////////////////////////////////////////////////////////////////////////
    // timing

    // slot index, one sweep is OPM_SLOTS phi1 cycles
    typedef logic [$clog2(`OPM_SLOTS)-1:0] slot_t;

endpackage

// ==== hdl/opm_timer.sv ====
`timescale 1ns/1ns

module opm_timer #(
    parameter int WIDTH    = 10,
    parameter int PRESCALE = 1
) (
    input  logic             i_emuclk,
    input  logic             i_rst_n,
    input  logic             i_slot_tick,   // once per 32-slot sweep
    input  logic             i_run,
    input  logic             i_irq_en,
    input  logic             i_flag_rst,
    input  logic [WIDTH-1:0] i_preset,
    output logic             o_flag
);

    localparam int PS_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [PS_W-1:0]  ps_cnt;
    logic             ps_last;
    logic             cnt_tick;
    logic [WIDTH-1:0] cnt;
    logic             ovfl;

    ////////////////////////////////////////////////////////////////////////////
    // prescaler

    // with PRESCALE of 1 this stays at zero and every tick counts
    assign ps_last  = (ps_cnt == PS_W'(PRESCALE - 1));
    assign cnt_tick = i_slot_tick & ps_last;

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            ps_cnt <= '0;
        end else if (!i_run) begin
            ps_cnt <= '0;
        end else if (i_slot_tick) begin
            ps_cnt <= ps_last ? '0 : ps_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main counter

    assign ovfl = i_run & cnt_tick & (&cnt);   // counting past all ones

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            cnt <= '0;
        end else if (!i_run) begin
            cnt <= i_preset;                    // parked on the preset
        end else if (cnt_tick) begin
            cnt <= ovfl ? i_preset : cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sticky flag

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_flag <= 1'b0;
        end else if (ovfl && i_irq_en) begin
            o_flag <= 1'b1;                     // set beats reset
        end else if (i_flag_rst) begin
            o_flag <= 1'b0;
        end
    end

endmodule

// ==== hdl/opm_timinggen.sv ====
`timescale 1ns/1ns
`include "opm_params.svh"

module opm_timinggen (
    input  logic            i_emuclk,
    input  logic            i_rst_n,
    input  logic            i_phim_pcen_n,  // phiM enable, active low
    output logic            o_phi1,
    output logic            o_phi1_cen,
    output logic            o_slot_tick,
    output opm_pkg::slot_t  o_slot
);
    import opm_pkg::*;

    logic phim_cen;

    assign phim_cen = ~i_phim_pcen_n;

    ////////////////////////////////////////////////////////////////////////////
    // phi1 and its enable

    // phi1 is phiM divided by two
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_phi1 <= 1'b0;
        end else if (phim_cen) begin
            o_phi1 <= ~o_phi1;
        end
    end

    assign o_phi1_cen = phim_cen & o_phi1;     // every second phiM enable

    ////////////////////////////////////////////////////////////////////////////
    // slot counter

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_slot <= '0;
        end else if (o_phi1_cen) begin
            o_slot <= o_slot + 1'b1;            // wraps 31 -> 0 by itself
        end
    end

    // end of sweep, one clock wide
    assign o_slot_tick = o_phi1_cen & (o_slot == slot_t'(`OPM_SLOTS - 1));

endmodule

// ==== hdl/opm_top.sv ====
`timescale 1ns/1ns
`include "opm_params.svh"

module opm_top (
    input  logic                i_emuclk,
    input  logic                i_rst_n,
    input  logic                i_phim_pcen_n,
    output logic                o_phi1,
    input  logic                i_cs_n,
    input  logic                i_rd_n,
    input  logic                i_wr_n,
    input  logic                i_a0,
    input  opm_pkg::bus_data_t  i_d,
    output opm_pkg::bus_data_t  o_d,
    output logic                o_d_oe,
    output logic                o_ct1,
    output logic                o_ct2,
    output logic                o_irq_n
);
    import opm_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // interconnect

    logic   phi1_cen;
    logic   slot_tick;
    slot_t  slot;                               // observed by the assertions
    clka_t  clka;
    clkb_t  clkb;
    logic   run_a, run_b;
    logic   irqen_a, irqen_b;
    logic   frst_a, frst_b;
    logic   flag_a, flag_b;

    ////////////////////////////////////////////////////////////////////////////
    // blocks

    opm_timinggen u_timinggen (
        .i_emuclk       (i_emuclk),
        .i_rst_n        (i_rst_n),
        .i_phim_pcen_n  (i_phim_pcen_n),
        .o_phi1         (o_phi1),
        .o_phi1_cen     (phi1_cen),
        .o_slot_tick    (slot_tick),
        .o_slot         (slot)
    );

    opm_bus_reg u_bus_reg (
        .i_emuclk   (i_emuclk),   .i_rst_n    (i_rst_n),    .i_phi1_cen (phi1_cen),
        .i_cs_n     (i_cs_n),     .i_rd_n     (i_rd_n),     .i_wr_n     (i_wr_n),
        .i_a0       (i_a0),       .i_d        (i_d),        .i_flag_a   (flag_a),
        .i_flag_b   (flag_b),     .o_d        (o_d),        .o_d_oe     (o_d_oe),
        .o_ct1      (o_ct1),      .o_ct2      (o_ct2),      .o_irq_n    (o_irq_n),
        .o_run_a    (run_a),      .o_run_b    (run_b),      .o_irqen_a  (irqen_a),
        .o_irqen_b  (irqen_b),    .o_frst_a   (frst_a),     .o_frst_b   (frst_b),
        .o_clka     (clka),       .o_clkb     (clkb)
    );

    // timer A, 10 bits, one count per sweep
    opm_timer #(.WIDTH(10), .PRESCALE(1)) u_timer_a (
        .i_emuclk (i_emuclk), .i_rst_n (i_rst_n), .i_slot_tick (slot_tick),
        .i_run (run_a), .i_irq_en (irqen_a), .i_flag_rst (frst_a),
        .i_preset (clka), .o_flag (flag_a)
    );

    // timer B, 8 bits behind the /16 prescaler
    opm_timer #(.WIDTH(8), .PRESCALE(`OPM_TIMERB_PRESCALE)) u_timer_b (
        .i_emuclk (i_emuclk), .i_rst_n (i_rst_n), .i_slot_tick (slot_tick),
        .i_run (run_b), .i_irq_en (irqen_b), .i_flag_rst (frst_b),
        .i_preset (clkb), .o_flag (flag_b)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module opm_tb -f filelist.f -o opm_sim &&
out="$(./obj_dir/opm_sim)" &&
echo "$out" &&
echo "$out" | grep -qx "Simulation passed" &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }

// ==== tests/opm_sva.sv ====
`timescale 1ns/1ns

module opm_sva (
    input logic i_emuclk,
    input logic i_rst_n,
    input logic i_cs_n,
    input logic i_rd_n,
    input logic i_wr_n,
    input logic i_a0,
    input logic i_d_oe,
    input logic i_ct1,
    input logic i_ct2,
    input logic i_irq_n,
    input opm_pkg::slot_t i_slot
);

    logic rd_act;
    logic wr_act;

    assign rd_act = !i_cs_n && !i_rd_n;
    assign wr_act = !i_cs_n && !i_wr_n;

    // output enable is the read strobe delayed by one clock
    a_oe_follows_read: assert property (@(posedge i_emuclk) disable iff (!i_rst_n)
        i_d_oe == $past(rd_act))
        else $error("o_d_oe does not follow the read strobe by one clock");

    // CT pins move only after the first clock of a data write
    a_ct_after_write: assert property (@(posedge i_emuclk) disable iff (!i_rst_n)
        !$stable({i_ct1, i_ct2}) |-> $past(wr_act && i_a0) && !$past(wr_act, 2))
        else $error("CT pins changed without a data write");

    // timer flags only set on the slot 31 to 0 wrap
    a_irq_at_sweep_end: assert property (@(posedge i_emuclk) disable iff (!i_rst_n)
        $fell(i_irq_n) |-> ($past(i_slot) == '1) && (i_slot == '0))
        else $error("o_irq_n fell away from the end of a sweep");

endmodule

bind opm_top opm_sva u_sva (
    .i_emuclk (i_emuclk),
    .i_rst_n  (i_rst_n),
    .i_cs_n   (i_cs_n),
    .i_rd_n   (i_rd_n),
    .i_wr_n   (i_wr_n),
    .i_a0     (i_a0),
    .i_d_oe   (o_d_oe),
    .i_ct1    (o_ct1),
    .i_ct2    (o_ct2),
    .i_irq_n  (o_irq_n),
    .i_slot   (slot)
);

// ==== tests/opm_tb.sv ====
`timescale 1ns/1ns
`include "opm_params.svh"

module opm_tb;
    import opm_pkg::*;

    // worst-case interrupt waits use the smallest presets in the random ranges
    localparam int TA_WAIT    = (1024 - 1016) * 64 + 64;
    localparam int TB_WAIT    = (256 - 250) * 1024 + 1024;
    localparam int MAX_CYCLES = TA_WAIT + 2 * TB_WAIT + 2000;  // timer B runs twice

    logic        emuclk;
    logic        rst_n;
    logic        phim_pcen_n;
    logic        cs_n;
    logic        rd_n;
    logic        wr_n;
    logic        a0;
    bus_data_t   d_in;
    bus_data_t   d_out;
    logic        d_oe;
    logic        phi1;
    logic        ct1;
    logic        ct2;
    logic        irq_n;
    logic [31:0] lfsr;
    int          data_errs;
    int          bit_errs;
    int          time_errs;
    int          cycles = 0;

    opm_top i_dut (
        .i_emuclk      (emuclk),
        .i_rst_n       (rst_n),
        .i_phim_pcen_n (phim_pcen_n),
        .o_phi1        (phi1),
        .i_cs_n        (cs_n),
        .i_rd_n        (rd_n),
        .i_wr_n        (wr_n),
        .i_a0          (a0),
        .i_d           (d_in),
        .o_d           (d_out),
        .o_d_oe        (d_oe),
        .o_ct1         (ct1),
        .o_ct2         (ct2),
        .o_irq_n       (irq_n)
    );

    initial begin
        emuclk = 1'b0;
        forever #20 emuclk = ~emuclk;
    end

    always @(posedge emuclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);                 // one step per bit
        end
    endtask

    // expected status byte
    function automatic bus_data_t status_byte(input logic busy, input logic fb, input logic fa);
        bus_data_t s;
        s = '0;
        s[`OPM_STAT_BUSY]   = busy;
        s[`OPM_STAT_FLAG_B] = fb;
        s[`OPM_STAT_FLAG_A] = fa;
        return s;
    endfunction

    task automatic check_data(input bus_data_t got, input bus_data_t exp, input string msg);
        if (got !== exp) begin
            data_errs++;
            $display("CHECK FAILED at %0t ns: %s, got %02h expected %02h", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            bit_errs++;
            $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge emuclk);
    endtask

    // one clock of strobe then one idle clock
    task automatic write_bus(input logic a, input bus_data_t v);
        @(negedge emuclk);
        cs_n = 1'b0;
        wr_n = 1'b0;
        a0   = a;
        d_in = v;
        @(negedge emuclk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic write_reg(input reg_addr_t addr, input bus_data_t v);
        write_bus(1'b0, addr);
        write_bus(1'b1, v);
    endtask

    task automatic read_status(output bus_data_t v);
        @(negedge emuclk);
        cs_n = 1'b0;
        rd_n = 1'b0;
        @(negedge emuclk);
        check_bit(d_oe, 1'b1, "o_d_oe during read");
        v    = d_out;
        cs_n = 1'b1;
        rd_n = 1'b1;
        @(negedge emuclk);
        check_bit(d_oe, 1'b0, "o_d_oe after read");
    endtask

    task automatic wait_irq_low(input int limit, output int waited);
        waited = 0;
        while (irq_n !== 1'b0 && waited <= limit) begin
            @(negedge emuclk);
            waited++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset();
        bus_data_t st;
        check_bit(irq_n, 1'b1, "o_irq_n after reset");
        check_bit(ct1, 1'b0, "o_ct1 after reset");
        check_bit(ct2, 1'b0, "o_ct2 after reset");
        check_bit(d_oe, 1'b0, "o_d_oe after reset");
        check_data(d_out, 8'h00, "o_d after reset");
        read_status(st);
        check_data(st, status_byte(1'b0, 1'b0, 1'b0), "status after reset");
    endtask

    // phiM enable every clock gives one phi1 period per two clocks
    task automatic test_phi1();
        logic prev;
        @(negedge emuclk);
        prev = phi1;
        repeat (64) begin
            @(negedge emuclk);
            check_bit(phi1, ~prev, "o_phi1 toggle");
            prev = phi1;
        end
    endtask

    task automatic test_ct_busy();
        bus_data_t st;
        bus_data_t v;
        for (int i = 0; i < 4; i++) begin
            v = '0;
            v[`OPM_BIT_CT1] = i[0];
            v[`OPM_BIT_CT2] = i[1];
            write_reg(`OPM_ADDR_CT, v);
            read_status(st);
            check_data(st, status_byte(1'b1, 1'b0, 1'b0), "busy right after data write");
            check_bit(ct1, i[0], "o_ct1 after CT write");
            check_bit(ct2, i[1], "o_ct2 after CT write");
            wait_clocks(70);
            read_status(st);
            check_data(st, status_byte(1'b0, 1'b0, 1'b0), "busy after 70 clocks");
        end
    endtask

    task automatic test_timer_a();
        logic [31:0] r;
        clka_t       n;
        bus_data_t   ctrl;
        bus_data_t   st;
        int          exp_clk;
        int          waited;
        take_bits(3, r);
        n = clka_t'(1016 + r[2:0]);
        write_reg(`OPM_ADDR_CLKA1, n[9:2]);
        write_reg(`OPM_ADDR_CLKA2, {6'b0, n[1:0]});
        ctrl = '0;
        ctrl[`OPM_BIT_RUN_A]   = 1'b1;
        ctrl[`OPM_BIT_IRQEN_A] = 1'b1;
        write_reg(`OPM_ADDR_TIMERCTRL, ctrl);
        exp_clk = (1024 - int'(n)) * 64;            // one count per 64-clock sweep
        wait_irq_low(exp_clk + 64, waited);
        if (waited < exp_clk - 64 || waited > exp_clk + 64) begin
            time_errs++;
            $display("timer A interrupt after %0d clocks, expected %0d +/- 64 (preset %0d)",
                     waited, exp_clk, n);
        end
        read_status(st);
        check_data(st, status_byte(1'b0, 1'b0, 1'b1), "status with flag A");
    endtask

    task automatic test_flag_reset_a();
        bus_data_t ctrl;
        bus_data_t st;
        ctrl = '0;
        ctrl[`OPM_BIT_FRST_A] = 1'b1;               // also stops timer A
        write_reg(`OPM_ADDR_TIMERCTRL, ctrl);
        wait_clocks(2);
        check_bit(irq_n, 1'b1, "o_irq_n after flag A reset");
        wait_clocks(70);
        read_status(st);
        check_data(st, status_byte(1'b0, 1'b0, 1'b0), "status after flag A reset");
    endtask

    task automatic test_timer_b();
        logic [31:0] r;
        clkb_t       n;
        bus_data_t   ctrl;
        bus_data_t   st;
        logic        all_high;
        int          exp_clk;
        int          waited;
        take_bits(3, r);
        n = clkb_t'(250 + r[2:0] % 6);
        write_reg(`OPM_ADDR_CLKB, n);
        ctrl = '0;
        ctrl[`OPM_BIT_RUN_B] = 1'b1;
        write_reg(`OPM_ADDR_TIMERCTRL, ctrl);
        exp_clk  = (256 - int'(n)) * 1024;          // 16 sweeps per count
        all_high = 1'b1;
        repeat (exp_clk + 1024) begin
            @(negedge emuclk);
            all_high = all_high & irq_n;
        end
        check_bit(all_high, 1'b1, "o_irq_n high with timer B IRQ off");
        read_status(st);
        check_data(st, status_byte(1'b0, 1'b0, 1'b0), "no flag B with IRQ off");
        ctrl[`OPM_BIT_IRQEN_B] = 1'b1;
        write_reg(`OPM_ADDR_TIMERCTRL, ctrl);
        wait_irq_low(exp_clk + 1024, waited);
        if (waited > exp_clk + 1024) begin
            time_errs++;
            $display("timer B interrupt missing after %0d clocks (preset %0d)", waited, n);
        end
        read_status(st);
        check_data(st, status_byte(1'b0, 1'b1, 1'b0), "status with flag B");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        rst_n       = 1'b0;
        phim_pcen_n = 1'b0;                         // held low all run
        cs_n        = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        a0          = 1'b0;
        d_in        = '0;
        lfsr        = 32'h6717_498b;
        data_errs   = 0;
        bit_errs    = 0;
        time_errs   = 0;
        repeat (5) @(negedge emuclk);
        rst_n = 1'b1;
        @(negedge emuclk);
        test_reset();
        test_phi1();
        test_ct_busy();
        test_timer_a();
        test_flag_reset_a();
        test_timer_b();
        $display("errors: %0d data, %0d bit, %0d timing", data_errs, bit_errs, time_errs);
        if (data_errs + bit_errs + time_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
